// ==== hw/am_inserter.sv ====
`timescale 1ns/1ps

module am_inserter import pcs_tx_pkg::*;
(
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_valid,
        input  logic [NB_BLOCK-1:0] i_data,
        input  logic                i_tag,
        output logic                o_valid,
        output logic [NB_BLOCK-1:0] o_data,
        output logic                o_am
);

        logic [NB_LANE_IDX-1:0] lane_idx;           // Lane for the next marker
        logic                   am_take;
        logic                   lane_last;

        assign am_take   = i_valid && i_tag;
        assign lane_last = (lane_idx == NB_LANE_IDX'(N_LANES - 1));

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        lane_idx <= '0;
                        o_valid  <= 1'b0;
                        o_am     <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                        o_am    <= am_take;
                        if (am_take)
                        begin
                                // Round robin over the lanes
                                if (lane_last)
                                        lane_idx <= '0;
                                else
                                        lane_idx <= lane_idx + 1'b1;
                        end
                end
        end

        // Tagged idle overwritten, everything else passes
        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_data <= i_tag ? am_lane_marker(lane_idx) : i_data;
        end

endmodule

// ==== hw/clock_comp_tx.sv ====
`timescale 1ns/1ps

module clock_comp_tx import pcs_tx_pkg::*;
(
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_valid,
        input  logic [NB_BLOCK-1:0] i_data,
        output logic                o_valid,
        output logic [NB_BLOCK-1:0] o_data,
        output logic                o_tag,
        output logic                o_fifo_overflow
);

        logic [NB_PERIOD_CNT-1:0] period_cnt;       // Valid blocks in this period
        logic [NB_LANE_IDX:0]     idle_cnt;         // Idles deleted, saturates at N_LANES
        logic                     period_end;
        logic                     slot;             // Marker slot position
        logic                     idle_del;         // Drop this input block
        logic                     fifo_write;
        logic                     fifo_read;
        logic [NB_BLOCK-1:0]      fifo_data;

        assign period_end = (period_cnt == NB_PERIOD_CNT'(PERIOD_BLOCKS - 1));
        assign slot       = (period_cnt < NB_PERIOD_CNT'(N_LANES));

        // Only the first N_LANES idles of a period are taken, slots included
        assign idle_del   = i_valid && (i_data == PCS_IDLE)
                            && (idle_cnt < (NB_LANE_IDX+1)'(N_LANES));

        assign fifo_write = i_valid && !idle_del;
        assign fifo_read  = i_valid && !slot;       // Slots hold the stream back

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        period_cnt <= '0;
                        idle_cnt   <= '0;
                end
                else if (i_valid)
                begin
                        if (period_end)
                        begin
                                period_cnt <= '0;
                                idle_cnt   <= '0;   // Fresh deletion budget
                        end
                        else
                        begin
                                period_cnt <= period_cnt + 1'b1;
                                if (idle_del)
                                        idle_cnt <= idle_cnt + 1'b1;
                        end
                end
        end

        // Output stage, one cycle
        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        o_valid <= 1'b0;
                        o_tag   <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                        o_tag   <= i_valid && slot;
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_data <= slot ? PCS_IDLE : fifo_data;   // Tagged idle fills the slot
        end

        sync_fifo u_sync_fifo
        (
                .i_clock    (i_clock),
                .i_rst_n    (i_rst_n),
                .i_write    (fifo_write),
                .i_read     (fifo_read),
                .i_data     (i_data),
                .o_data     (fifo_data),
                .o_overflow (o_fifo_overflow)
        );

endmodule

// ==== hw/pcs_tx_pkg.sv ====
package pcs_tx_pkg;

        localparam int NB_BLOCK        = 66;         // Sync header in [65:64]
        localparam int NB_PAYLOAD      = 64;         // Scrambled part
        localparam int N_LANES         = 20;         // PCS lanes, markers per period
        localparam int AM_BLOCK_PERIOD = 16383;      // Blocks per lane between markers

        localparam int PERIOD_BLOCKS   = AM_BLOCK_PERIOD * N_LANES;
        localparam int NB_PERIOD_CNT   = $clog2(PERIOD_BLOCKS);
        localparam int NB_LANE_IDX     = $clog2(N_LANES);
        localparam int NB_FIFO_ADDR    = 5;          // 32 entries

        // Full idle block, control header and type 0x1E
        localparam logic [NB_BLOCK-1:0] PCS_IDLE = {2'b10, 8'h1E, 56'd0};

        // Marker for one lane, first byte sent sits at the top
        function automatic logic [NB_BLOCK-1:0] am_lane_marker(input logic [NB_LANE_IDX-1:0] lane);
                logic [23:0] m;                      // M0 M1 M2
                case (lane)
                        5'd0:    m = 24'hC1_68_21;
                        5'd1:    m = 24'h9D_71_8E;
                        5'd2:    m = 24'h59_4B_E8;
                        5'd3:    m = 24'h4D_95_7B;
                        5'd4:    m = 24'hF5_07_09;
                        5'd5:    m = 24'hDD_14_C2;
                        5'd6:    m = 24'h9A_4A_26;
                        5'd7:    m = 24'h7B_45_66;
                        5'd8:    m = 24'hA0_24_76;
                        5'd9:    m = 24'h68_C9_FB;
                        5'd10:   m = 24'hFD_6C_99;
                        5'd11:   m = 24'hB9_91_55;
                        5'd12:   m = 24'h5C_B9_B2;
                        5'd13:   m = 24'h1A_F8_BD;
                        5'd14:   m = 24'h83_C7_CA;
                        5'd15:   m = 24'h35_36_CD;
                        5'd16:   m = 24'hC4_31_4C;
                        5'd17:   m = 24'hAD_D6_B7;
                        5'd18:   m = 24'h5F_66_2A;
                        5'd19:   m = 24'hC0_F0_E5;
                        default: m = 24'h00_00_00;   // Unused lane numbers
                endcase
                // Sync 01, lane bytes, BIP3, inverted bytes, BIP7
                // BIP fields left zero for the per-lane stage
                return {2'b01, m, 8'h00, ~m, 8'h00};
        endfunction

endpackage

// ==== hw/pcs_tx_top.sv ====
`timescale 1ns/1ps

module pcs_tx_top import pcs_tx_pkg::*;
(
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_valid,
        input  logic [NB_BLOCK-1:0] i_data,
        output logic                o_valid,
        output logic [NB_BLOCK-1:0] o_data,
        output logic                o_am,
        output logic                o_fifo_overflow
);

        logic                cc_valid;              // Clock comp to scrambler
        logic [NB_BLOCK-1:0] cc_data;
        logic                cc_tag;
        logic                scr_valid;             // Scrambler to marker insert
        logic [NB_BLOCK-1:0] scr_data;
        logic                scr_tag;

        clock_comp_tx u_clock_comp_tx
        (
                .i_clock (i_clock),    .i_rst_n (i_rst_n),
                .i_valid (i_valid),    .i_data  (i_data),
                .o_valid (cc_valid),   .o_data  (cc_data),
                .o_tag   (cc_tag),     .o_fifo_overflow (o_fifo_overflow)
        );

        tx_scrambler u_tx_scrambler
        (
                .i_clock (i_clock),    .i_rst_n (i_rst_n),
                .i_valid (cc_valid),   .i_data  (cc_data),   .i_tag (cc_tag),
                .o_valid (scr_valid),  .o_data  (scr_data),  .o_tag (scr_tag)
        );

        am_inserter u_am_inserter
        (
                .i_clock (i_clock),    .i_rst_n (i_rst_n),
                .i_valid (scr_valid),  .i_data  (scr_data),  .i_tag (scr_tag),
                .o_valid (o_valid),    .o_data  (o_data),    .o_am  (o_am)
        );

endmodule

// ==== hw/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo import pcs_tx_pkg::*;
(
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_write,
        input  logic                i_read,
        input  logic [NB_BLOCK-1:0] i_data,
        output logic [NB_BLOCK-1:0] o_data,
        output logic                o_overflow
);

        localparam int DEPTH = 2 ** NB_FIFO_ADDR;

        logic [NB_BLOCK-1:0]     mem [DEPTH];       // Block storage, no reset
        logic [NB_FIFO_ADDR-1:0] wr_ptr;
        logic [NB_FIFO_ADDR-1:0] rd_ptr;
        logic [NB_FIFO_ADDR:0]   count;             // Occupancy, 0 to DEPTH
        logic                    empty;
        logic                    full;
        logic                    wr_ok;
        logic                    rd_ok;

        assign empty = (count == '0);
        assign full  = (count == (NB_FIFO_ADDR+1)'(DEPTH));

        // Full with a read in the same cycle still takes the write
        assign wr_ok = i_write && (!full || i_read);
        // Empty read only served by a same-cycle write
        assign rd_ok = i_read && (!empty || i_write);

        // Bypass so an empty FIFO adds no latency
        assign o_data = empty ? i_data : mem[rd_ptr];

        always_ff @(posedge i_clock)
        begin
                if (wr_ok)
                begin
                        mem[wr_ptr] <= i_data;
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        wr_ptr     <= '0;
                        rd_ptr     <= '0;
                        count      <= '0;
                        o_overflow <= 1'b0;
                end
                else
                begin
                        if (wr_ok)
                                wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
                        if (rd_ok)
                                rd_ptr <= rd_ptr + 1'b1;
                        count <= count + (NB_FIFO_ADDR+1)'(wr_ok) - (NB_FIFO_ADDR+1)'(rd_ok);
                        if (i_write && !wr_ok)
                                o_overflow <= 1'b1;        // Sticky until reset
                end
        end

endmodule

// ==== hw/tx_scrambler.sv ====
`timescale 1ns/1ps

module tx_scrambler import pcs_tx_pkg::*;
(
        input  logic                i_clock,
        input  logic                i_rst_n,
        input  logic                i_valid,
        input  logic [NB_BLOCK-1:0] i_data,
        input  logic                i_tag,
        output logic                o_valid,
        output logic [NB_BLOCK-1:0] o_data,
        output logic                o_tag
);

        logic [57:0]           scr_state;           // Last 58 scrambled bits, [0] newest
        logic [57:0]           scr_next;
        logic [NB_PAYLOAD-1:0] scr_out;

        // 1 + x^39 + x^58, bit 0 goes first
        always_comb
        begin
                scr_next = scr_state;
                for (int i = 0; i < NB_PAYLOAD; i++)
                begin
                        scr_out[i] = i_data[i] ^ scr_next[38] ^ scr_next[57];
                        scr_next   = {scr_next[56:0], scr_out[i]};   // Feed back scrambled bit
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        scr_state <= '1;
                        o_valid   <= 1'b0;
                        o_tag     <= 1'b0;
                end
                else
                begin
                        o_valid <= i_valid;
                        if (i_valid)
                                o_tag <= i_tag;
                        if (i_valid && !i_tag)
                                scr_state <= scr_next;   // Tagged slots leave state alone
                end
        end

        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                        o_data <= i_tag ? i_data : {i_data[NB_BLOCK-1 -: 2], scr_out};
        end

endmodule

// ==== list.f ====
hw/pcs_tx_pkg.sv
hw/sync_fifo.sv
hw/clock_comp_tx.sv
hw/tx_scrambler.sv
hw/am_inserter.sv
hw/pcs_tx_top.sv
test/tb_clock_gen.sv
test/tb_pcs_tx.sv

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
        input  logic i_reset_req,               // Restart the reset pulse
        output logic o_clock,
        output logic o_rst_n
);

        localparam int RST_CYCLES = 16;

        int rst_cnt;

        initial
        begin
                o_clock = 1'b0;
                forever #4 o_clock = ~o_clock;   // 8 ns period
        end

        initial
        begin
                o_rst_n = 1'b0;                 // Held low from time zero
                rst_cnt = RST_CYCLES;
        end

        always @(posedge o_clock)
        begin
                if (i_reset_req)
                begin
                        rst_cnt <= RST_CYCLES;
                        o_rst_n <= 1'b0;
                end
                else if (rst_cnt != 0)
                begin
                        rst_cnt <= rst_cnt - 1;
                        if (rst_cnt == 1)
                                o_rst_n <= 1'b1;   // Release after 16 edges
                end
        end

endmodule

// ==== test/tb_pcs_tx.sv ====
`timescale 1ns/1ps

module tb_pcs_tx import pcs_tx_pkg::*;
();

        localparam int          MODEL_PERIOD = AM_BLOCK_PERIOD * N_LANES;   // Valid blocks
        localparam int          PIPE_LATENCY = 3;                 // Three registered stages
        localparam int          WAIT_TIMEOUT = 100;               // Cycles for any wait
        localparam int unsigned RAND_SEED    = 32'h7381_1213;

        // Marker bytes M0 M1 M2, lane 0 first
        localparam logic [N_LANES*24-1:0] AM_TABLE = {
                24'hC16821, 24'h9D718E, 24'h594BE8, 24'h4D957B, 24'hF50709,
                24'hDD14C2, 24'h9A4A26, 24'h7B4566, 24'hA02476, 24'h68C9FB,
                24'hFD6C99, 24'hB99155, 24'h5CB9B2, 24'h1AF8BD, 24'h83C7CA,
                24'h3536CD, 24'hC4314C, 24'hADD6B7, 24'h5F662A, 24'hC0F0E5};

        logic                clock;
        logic                rst_n;
        logic                reset_req;
        logic                i_valid;
        logic [NB_BLOCK-1:0] i_data;
        logic                o_valid;
        logic [NB_BLOCK-1:0] o_data;
        logic                o_am;
        logic                o_fifo_overflow;

        logic [NB_BLOCK-1:0] kept_q [$];        // Blocks that survive deletion
        logic [NB_BLOCK-1:0] exp_blk [$];       // One entry per valid input
        logic                exp_am [$];
        int                  exp_due [$];       // Cycle the block is due at the output
        int                  mdl_pos;           // Position in the period
        int                  mdl_del;           // Idles deleted this period
        int                  mdl_lane;
        logic [57:0]         dsc_state;         // Last 58 received scrambled bits
        logic                model_on;
        int                  cyc;               // Counts falling edges
        int                  idles_out;
        int                  err_cnt;
        int                  check_cnt;
        int                  test_cnt;
        int unsigned         seed_ret;

        tb_clock_gen u_clock_gen (.i_reset_req (reset_req), .o_clock (clock), .o_rst_n (rst_n));

        pcs_tx_top uut
        (
                .i_clock (clock),    .i_rst_n (rst_n),
                .i_valid (i_valid),  .i_data  (i_data),
                .o_valid (o_valid),  .o_data  (o_data),
                .o_am    (o_am),     .o_fifo_overflow (o_fifo_overflow)
        );

        task automatic check_block(input string name, input logic [NB_BLOCK-1:0] got, want);
                check_cnt++;
                if (got !== want)
                begin
                        $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, want);
                        err_cnt++;
                end
        endtask

        task automatic check_flag(input string name, input logic got, want);
                check_cnt++;
                if (got !== want)
                begin
                        $display("CHECK FAILED t=%0t %s got %b expected %b", $time, name, got, want);
                        err_cnt++;
                end
        endtask

        task automatic timeout_fail(input string what);
                $display("TIMEOUT t=%0t %s", $time, what);
                err_cnt++;
        endtask

        function automatic logic [NB_BLOCK-1:0] rand_data();
                return {2'b01, $urandom(), $urandom()};   // Data header, never an idle
        endfunction

        // x^39 + x^58 taps on received bits, bit 0 first
        function automatic logic [NB_PAYLOAD-1:0] descramble(input logic [NB_PAYLOAD-1:0] rx);
                logic [NB_PAYLOAD-1:0] plain;
                for (int i = 0; i < NB_PAYLOAD; i++)
                begin
                        plain[i]  = rx[i] ^ dsc_state[38] ^ dsc_state[57];
                        dsc_state = {dsc_state[56:0], rx[i]};
                end
                return plain;
        endfunction

        task automatic model_reset();
                kept_q.delete();
                exp_blk.delete();
                exp_am.delete();
                exp_due.delete();
                mdl_pos   = 0;
                mdl_del   = 0;
                mdl_lane  = 0;
                dsc_state = '1;
        endtask

        // Stream rule for one valid input block
        task automatic model_push(input logic [NB_BLOCK-1:0] blk);
                logic [23:0] m;
                if (blk == PCS_IDLE && mdl_del < N_LANES)
                        mdl_del++;                      // Pays back one slot
                else
                        kept_q.push_back(blk);
                if (mdl_pos < N_LANES)
                begin
                        m = AM_TABLE[(N_LANES-1-mdl_lane)*24 +: 24];
                        exp_blk.push_back({2'b01, m, 8'h00, ~m, 8'h00});
                        exp_am.push_back(1'b1);
                        mdl_lane = (mdl_lane + 1) % N_LANES;
                end
                else
                begin
                        exp_blk.push_back(kept_q.pop_front());
                        exp_am.push_back(1'b0);
                end
                exp_due.push_back(cyc + 1 + PIPE_LATENCY);   // Input seen at next falling edge
                mdl_pos++;
                if (mdl_pos == MODEL_PERIOD)
                begin
                        mdl_pos = 0;
                        mdl_del = 0;
                end
        endtask

        task automatic drive_cycle(input logic valid, input logic [NB_BLOCK-1:0] data);
                @(posedge clock);
                i_valid <= valid;
                i_data  <= data;
                if (valid && model_on)
                        model_push(data);
        endtask

        task automatic wait_drain();
                int t;
                t = 0;
                while (exp_blk.size() != 0 && t < WAIT_TIMEOUT)
                begin
                        drive_cycle(1'b0, '0);
                        t++;
                end
                if (exp_blk.size() != 0)
                        timeout_fail("expected output blocks never arrived");
        endtask

        // Outputs stay low in reset and the first cycle after it
        task automatic wait_reset();
                int t;
                t = 0;
                do
                begin
                        @(negedge clock);
                        check_flag("o_valid", o_valid, 1'b0);
                        check_flag("o_am", o_am, 1'b0);
                        check_flag("o_fifo_overflow", o_fifo_overflow, 1'b0);
                        t++;
                end
                while (rst_n !== 1'b1 && t < WAIT_TIMEOUT);
                if (rst_n !== 1'b1)
                        timeout_fail("reset never released");
        endtask

        task automatic apply_reset();
                @(posedge clock);
                reset_req <= 1'b1;
                i_valid   <= 1'b0;
                @(posedge clock);
                reset_req <= 1'b0;
                wait_reset();
        endtask

        task automatic end_test(input string name, input int e0);
                $display("test %s finished, %0d errors", name, err_cnt - e0);
                test_cnt++;
        endtask

        task automatic test_reset_markers();
                int e0;
                e0 = err_cnt;
                wait_reset();
                for (int n = 0; n < 2 * N_LANES; n++)
                        drive_cycle(1'b1, rand_data());   // 20 slots, then data
                wait_drain();
                end_test("reset_markers", e0);
        endtask

        task automatic test_order_scramble();
                int e0;
                int n_blk;
                e0    = err_cnt;
                n_blk = 2 * MODEL_PERIOD - mdl_pos;   // Up to the end of the second period
                for (int n = 0; n < n_blk; n++)
                        drive_cycle(1'b1, ($urandom() % 64 == 0) ? PCS_IDLE : rand_data());
                wait_drain();
                end_test("order_scramble", e0);
        endtask

        task automatic test_delete_limit();
                int e0;
                int idles0;
                e0     = err_cnt;
                idles0 = idles_out;
                // Idles at 4, 9 .. 149, four of them inside the slots
                for (int p = 0; p < MODEL_PERIOD; p++)
                        drive_cycle(1'b1, (p % 5 == 4 && p < 150) ? PCS_IDLE : rand_data());
                wait_drain();
                if (idles_out - idles0 != 30 - N_LANES)
                begin
                        $display("ERROR t=%0t %0d idles reached the output, expected %0d",
                                 $time, idles_out - idles0, 30 - N_LANES);
                        err_cnt++;
                end
                end_test("delete_limit", e0);
        endtask

        task automatic test_valid_gaps();
                int e0;
                e0 = err_cnt;
                for (int c = 0; c < 3000; c++)
                begin
                        if ($urandom() % 4 == 0)
                                drive_cycle(1'b0, rand_data());   // Gap, data ignored
                        else
                                drive_cycle(1'b1, ($urandom() % 8 == 0) ? PCS_IDLE : rand_data());
                end
                wait_drain();
                end_test("valid_gaps", e0);
        endtask

        task automatic test_overflow();
                int   e0;
                int   t;
                logic seen;
                e0       = err_cnt;
                model_on = 1'b0;                        // Dropped writes break the model
                apply_reset();
                model_reset();
                seen = 1'b0;
                t    = 0;
                while (!seen && t < MODEL_PERIOD + WAIT_TIMEOUT)
                begin
                        drive_cycle(1'b1, rand_data());
                        @(negedge clock);
                        seen = o_fifo_overflow;
                        t++;
                end
                if (!seen || t <= MODEL_PERIOD)
                begin
                        $display("ERROR t=%0t overflow flag rose after %0d blocks, expected %0d+",
                                 $time, t, MODEL_PERIOD);
                        err_cnt++;
                end
                repeat (50)
                begin
                        drive_cycle(1'b1, rand_data());
                        @(negedge clock);
                        check_flag("o_fifo_overflow", o_fifo_overflow, 1'b1);   // Sticky
                end
                apply_reset();                          // Flag cleared only here
                end_test("overflow", e0);
        endtask

        always @(negedge clock)
        begin : monitor
                logic [NB_BLOCK-1:0] want;
                logic [NB_BLOCK-1:0] plain;
                logic                want_am;
                int                  due;
                cyc = cyc + 1;
                if (o_valid === 1'b1 && model_on)
                begin
                        if (exp_blk.size() == 0)
                        begin
                                $display("ERROR t=%0t o_valid high with no matching input", $time);
                                err_cnt++;
                        end
                        else
                        begin
                                want    = exp_blk.pop_front();
                                want_am = exp_am.pop_front();
                                due     = exp_due.pop_front();
                                if (cyc != due)
                                begin
                                        $display("ERROR t=%0t block out at cycle %0d, due at %0d",
                                                 $time, cyc, due);
                                        err_cnt++;
                                end
                                check_flag("o_am", o_am, want_am);
                                if (want_am)
                                        check_block("o_data", o_data, want);   // Marker as sent
                                else
                                begin
                                        plain = {o_data[NB_BLOCK-1 -: 2],
                                                 descramble(o_data[NB_PAYLOAD-1:0])};
                                        check_block("o_data descrambled", plain, want);
                                        if (plain == PCS_IDLE)
                                                idles_out++;
                                end
                        end
                end
        end

        initial
        begin
                reset_req = 1'b0;
                i_valid   = 1'b0;
                i_data    = '0;
                model_on  = 1'b1;
                cyc       = 0;
                idles_out = 0;
                err_cnt   = 0;
                check_cnt = 0;
                test_cnt  = 0;
                model_reset();
                seed_ret  = $urandom(RAND_SEED);
                test_reset_markers();
                test_order_scramble();
                test_delete_limit();
                test_valid_gaps();
                test_overflow();
                $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
                if (err_cnt == 0)
                        $display("TESTS PASSED");
                else
                        $display("TESTS FAILED");
                $finish;
        end

endmodule
